/* sources.f */
source/lfbuf_pkg.sv
source/lfbuf_line_ram.sv
source/lfbuf_line_writer.sv
source/lfbuf_scan_reader.sv
source/lfbuf_ddr_arbiter.sv
source/lfbuf_top.sv
bench/tb_clock.sv
bench/ddr_model.sv
bench/lfbuf_assertions.sv
bench/lfbuf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the lfbuf testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module lfbuf_tb \
    -f sources.f \
    -o Vlfbuf_tb

output=$(./obj_dir/Vlfbuf_tb)
echo "$output"

if grep -q "TEST PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* bench/lfbuf_tb.sv */
// **************************************************
// table-driven test of copy, clear, bank swap and read-back
// HW is 4 so each line is 16 pixels
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module lfbuf_tb import lfbuf_pkg::*;;

    localparam int HW    = 4;
    localparam int VW    = 8;
    localparam int STEPS = 8;
    localparam int LIMIT = STEPS * (2**HW * 8 + 64);
    localparam logic [1:0] ACT_WRITE = 2'd0;
    localparam logic [1:0] ACT_READ  = 2'd1;
    localparam logic [1:0] ACT_BOTH  = 2'd2;

    // write fields row/seed/partial, read fields vrow/vseed/vpartial
    typedef struct packed {
        logic [1:0]    act;
        logic          frame;
        logic [VW-1:0] row;
        logic [7:0]    seed;
        logic          partial;
        logic [VW-1:0] vrow;
        logic [7:0]    vseed;
        logic          vpartial;
    } step_t;

    logic clk, rst;
    logic pxl_we, ln_done, lhbl, frame;
    logic [HW-1:0] pxl_addr, scr_addr;
    pixel_t pxl_data, scr_data;
    logic [VW-1:0] ln_v, vrender;
    logic line, fb_done;
    logic busy, dout_ready, ddram_rd, ddram_we;
    logic [DDR_DW-1:0] dout, ddram_din;
    logic [DDR_AW-1:0] ddram_addr;
    logic [7:0] ddram_be;
    logic [HW:0] ddram_burstcnt;
    int bad_addr;

    step_t steps [0:STEPS-1];
    int errors, cycles, fb_count, fb_target, beat_count, beat_target, toggles, copies;
    logic fb_l, line_l, line_exp;

    tb_clock clock_i (.clk(clk), .rst(rst));

    ddr_model #(.HW(HW), .VW(VW), .LAT(6), .SEED(80255)) ddr_i (
        .clk(clk), .rst(rst), .rd(ddram_rd), .we(ddram_we), .addr(ddram_addr),
        .din(ddram_din), .be(ddram_be), .burstcnt(ddram_burstcnt), .busy(busy),
        .dout_ready(dout_ready), .dout(dout), .bad_addr(bad_addr)
    );

    lfbuf_top #(.HW(HW), .VW(VW)) dut_i (
        .clk(clk), .rst(rst), .pxl_we(pxl_we), .pxl_addr(pxl_addr), .pxl_data(pxl_data),
        .ln_done(ln_done), .ln_v(ln_v), .vrender(vrender), .lhbl(lhbl), .frame(frame),
        .scr_addr(scr_addr), .scr_data(scr_data), .line(line), .fb_done(fb_done),
        .ddram_busy(busy), .ddram_dout_ready(dout_ready), .ddram_dout(dout),
        .ddram_rd(ddram_rd), .ddram_we(ddram_we), .ddram_addr(ddram_addr),
        .ddram_din(ddram_din), .ddram_be(ddram_be), .ddram_burstcnt(ddram_burstcnt)
    );

    bind lfbuf_ddr_arbiter lfbuf_assertions #(.HW(HW)) assertions_i (
        .clk(clk), .rst(rst), .ddram_rd(ddram_rd), .ddram_we(ddram_we),
        .ddram_busy(ddram_busy), .ddram_addr(ddram_addr)
    );

    // odd pixels of a partial line are expected to be zero
    function automatic pixel_t pixel_value(logic [7:0] seed, logic partial, int i);
        if (partial && i[0]) begin
            return '0;
        end
        return {seed, 4'h5, 4'(i)};
    endfunction

    task automatic report_mismatch(string what, int i, pixel_t got, pixel_t exp);
        $display("[FAIL] %0t ns %s pixel %0d got %h expected %h", $time, what, i, got, exp);
        errors++;
    endtask

    task automatic render_line(logic [7:0] seed, logic partial);
        for (int i = 0; i < 2**HW; i++) begin
            @(posedge clk);
            pxl_we   <= !(partial && i[0]);
            pxl_addr <= HW'(i);
            pxl_data <= pixel_value(seed, 1'b0, i);
        end
        @(posedge clk);
        pxl_we <= 1'b0;
    endtask

    task automatic start_copy(logic f, logic [VW-1:0] row);
        @(posedge clk);
        // line starts at 0 and flips once per finished line
        line_exp <= ~line_exp;
        frame    <= f;
        ln_v     <= row;
        ln_done  <= 1'b1;
        fb_target++;
        copies++;
        @(posedge clk);
        ln_done <= 1'b0;
    endtask

    task automatic start_blank(logic f, logic [VW-1:0] row);
        @(posedge clk);
        frame   <= f;
        vrender <= row;
        lhbl    <= 1'b1;
        beat_target += 2**HW;
        @(posedge clk);
        lhbl <= 1'b0;
    endtask

    task automatic check_screen(logic [7:0] seed, logic partial);
        for (int i = 0; i < 2**HW; i++) begin
            @(posedge clk);
            scr_addr <= HW'(i);
            @(negedge clk);
            if (scr_data !== pixel_value(seed, partial, i)) begin
                report_mismatch("screen", i, scr_data, pixel_value(seed, partial, i));
            end
        end
    endtask

    // fb_done pulses, line toggles, returned read beats and fixed DDR pins
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            fb_count   <= 0;
            beat_count <= 0;
            toggles    <= 0;
            fb_l       <= 1'b0;
            line_l     <= 1'b0;
        end else begin
            fb_l   <= fb_done;
            line_l <= line;
            if (fb_done) begin
                fb_count <= fb_count + 1;
            end
            if (dout_ready) begin
                beat_count <= beat_count + 1;
            end
            if (line != line_l) begin
                toggles <= toggles + 1;
            end
            if (fb_done && fb_l) begin
                $display("[FAIL] %0t ns fb_done longer than one cycle", $time);
                errors++;
            end
            // low two byte enables and one line per burst
            if ((ddram_rd || ddram_we) &&
                (ddram_be !== 8'h03 || ddram_burstcnt !== (HW+1)'(2**HW))) begin
                $display("[FAIL] %0t ns be %h burstcnt %0d on a DDR access",
                    $time, ddram_be, ddram_burstcnt);
                errors++;
            end
            if (ddram_we && ddram_din[DDR_DW-1:16] !== '0) begin
                $display("[FAIL] %0t ns write data outside the low 16 bits", $time);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        pxl_we      = 1'b0;
        pxl_addr    = '0;
        pxl_data    = '0;
        ln_done     = 1'b0;
        ln_v        = '0;
        vrender     = '0;
        lhbl        = 1'b0;
        frame       = 1'b0;
        scr_addr    = '0;
        line_exp    = 1'b0;
        errors      = 0;
        cycles      = 0;
        fb_target   = 0;
        beat_target = 0;
        copies      = 0;
        steps[0] = {ACT_WRITE, 1'b0, 8'd5, 8'ha1, 1'b0, 8'd0, 8'h00, 1'b0};
        steps[1] = {ACT_READ,  1'b1, 8'd0, 8'h00, 1'b0, 8'd5, 8'ha1, 1'b0};
        steps[2] = {ACT_WRITE, 1'b1, 8'd5, 8'hb2, 1'b0, 8'd0, 8'h00, 1'b0};
        steps[3] = {ACT_WRITE, 1'b0, 8'd6, 8'hc3, 1'b1, 8'd0, 8'h00, 1'b0};
        steps[4] = {ACT_READ,  1'b1, 8'd0, 8'h00, 1'b0, 8'd6, 8'hc3, 1'b1};
        steps[5] = {ACT_READ,  1'b0, 8'd0, 8'h00, 1'b0, 8'd5, 8'hb2, 1'b0};
        steps[6] = {ACT_BOTH,  1'b0, 8'd7, 8'hd4, 1'b0, 8'd5, 8'hb2, 1'b0};
        steps[7] = {ACT_READ,  1'b1, 8'd0, 8'h00, 1'b0, 8'd7, 8'hd4, 1'b0};

        @(negedge rst);
        @(negedge clk);
        if (line !== 1'b0 || fb_done !== 1'b0 || ddram_rd !== 1'b0 || ddram_we !== 1'b0) begin
            $display("[FAIL] %0t ns outputs not zero after reset", $time);
            errors++;
        end

        foreach (steps[s]) begin
            if (steps[s].act != ACT_READ) begin
                render_line(steps[s].seed, steps[s].partial);
                start_copy(steps[s].frame, steps[s].row);
            end
            // blank arrives while the write burst is running
            if (steps[s].act == ACT_BOTH) begin
                repeat (4) @(posedge clk);
            end
            if (steps[s].act != ACT_WRITE) begin
                start_blank(steps[s].frame, steps[s].vrow);
            end
            while (fb_count < fb_target || beat_count < beat_target) begin
                @(posedge clk);
            end
            // last beat still has to land in the screen memory
            repeat (4) @(posedge clk);
            if (steps[s].act != ACT_READ && line !== line_exp) begin
                $display("[FAIL] %0t ns line is %b, expected %b at step %0d",
                    $time, line, line_exp, s);
                errors++;
            end
            if (steps[s].act != ACT_WRITE) begin
                check_screen(steps[s].vseed, steps[s].vpartial);
            end
        end

        // every written line must sit in the model at {bank, row, pixel}
        foreach (steps[s]) begin
            if (steps[s].act != ACT_READ) begin
                for (int i = 0; i < 2**HW; i++) begin
                    if (ddr_i.mem[{steps[s].frame, steps[s].row, HW'(i)}] !==
                        pixel_value(steps[s].seed, steps[s].partial, i)) begin
                        report_mismatch("ddr", i,
                            ddr_i.mem[{steps[s].frame, steps[s].row, HW'(i)}],
                            pixel_value(steps[s].seed, steps[s].partial, i));
                    end
                end
            end
        end
        if (fb_count != copies || toggles != copies) begin
            $display("[FAIL] %0t ns %0d copies gave %0d fb_done and %0d toggles",
                $time, copies, fb_count, toggles);
            errors++;
        end
        if (bad_addr != 0) begin
            $display("[FAIL] %0t ns %0d DDR accesses outside the frame area", $time, bad_addr);
            errors++;
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/lfbuf_assertions.sv */
// **************************************************
// DDR strobe and burst rules, bound into the arbiter
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module lfbuf_assertions import lfbuf_pkg::*; #(
    parameter int HW = 9
) (
    input logic              clk,
    input logic              rst,
    input logic              ddram_rd,
    input logic              ddram_we,
    input logic              ddram_busy,
    input logic [DDR_AW-1:0] ddram_addr
);

    logic we_l;
    int   wr_cnt;

    // counts accepted write beats of the current burst
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            we_l   <= 1'b0;
            wr_cnt <= 0;
        end else begin
            we_l <= ddram_we;
            if (!ddram_we) begin
                wr_cnt <= 0;
            end else if (!ddram_busy) begin
                wr_cnt <= wr_cnt + 1;
            end
        end
    end

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ddram_rd && ddram_we))
        else $error("rd and we high together");

    addr_held: assert property (@(posedge clk) disable iff (rst)
        (ddram_busy && (ddram_rd || ddram_we)) |=> $stable(ddram_addr))
        else $error("address moved while busy");

    burst_length: assert property (@(posedge clk) disable iff (rst)
        (we_l && !ddram_we) |-> (wr_cnt == 2**HW))
        else $error("write burst length wrong");

endmodule

`default_nettype wire

/* bench/ddr_model.sv */
// **************************************************
// behavioral DDR memory, random busy and fixed read latency
// stores only the frame area, index is {bank, row, pixel}
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module ddr_model import lfbuf_pkg::*; #(
    parameter int HW   = 9,
    parameter int VW   = 8,
    parameter int LAT  = 6,
    parameter int SEED = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd,
    input  logic              we,
    input  logic [DDR_AW-1:0] addr,
    input  logic [DDR_DW-1:0] din,
    input  logic [7:0]        be,
    input  logic [HW:0]       burstcnt,
    output logic              busy,
    output logic              dout_ready,
    output logic [DDR_DW-1:0] dout,
    output int                bad_addr
);

    localparam int MW = 1 + VW + HW;

    logic [15:0]   mem [0:(2**MW)-1];
    integer        seed;
    logic [MW-1:0] idx;
    logic [MW-1:0] ptr;
    logic          addr_ok;
    int            lat_left;
    logic [HW:0]   beats_left;

    assign idx     = addr[MW-1:0];
    assign addr_ok = (addr[DDR_AW-1:DDR_AW-4] == DDR_BASE) && (addr[DDR_AW-5:MW] == '0);

    // fill pattern from the whole index so stale words stand out
    initial begin
        seed = SEED;
        for (int i = 0; i < 2**MW; i++) begin
            mem[i] = 16'hc000 ^ 16'(i);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            dout_ready <= 1'b0;
            dout       <= '0;
            lat_left   <= 0;
            beats_left <= '0;
            ptr        <= '0;
            bad_addr   <= 0;
        end else begin
            // roughly one stall in four
            busy       <= (($random(seed) & 3) == 0);
            dout_ready <= 1'b0;
            if ((we || rd) && !busy && !addr_ok) begin
                bad_addr <= bad_addr + 1;
            end
            if (we && !busy && be[1:0] == 2'b11) begin
                mem[idx] <= din[15:0];
            end
            if (rd && !busy) begin
                ptr        <= idx;
                lat_left   <= LAT;
                beats_left <= burstcnt;
            end else if (lat_left != 0) begin
                lat_left <= lat_left - 1;
            end else if (beats_left != 0) begin
                dout_ready <= 1'b1;
                dout       <= {{(DDR_DW-16){1'b0}}, mem[ptr]};
                ptr        <= ptr + 1'b1;
                beats_left <= beats_left - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
// **************************************************
// testbench clock of 4 ns, reset held for 16 cycles
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* source/lfbuf_top.sv */
// **************************************************
// line-to-frame buffer, render line to DDR to screen line
// a line is one DDR burst of 2^HW pixels
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module lfbuf_top import lfbuf_pkg::*; #(
    parameter int HW = 9,
    parameter int VW = 8
) (
    input  logic              clk,
    input  logic              rst,
    // renderer side
    input  logic              pxl_we,
    input  logic [HW-1:0]     pxl_addr,
    input  pixel_t            pxl_data,
    input  logic              ln_done,
    input  logic [VW-1:0]     ln_v,
    input  logic [VW-1:0]     vrender,
    input  logic              lhbl,
    input  logic              frame,
    // video out
    input  logic [HW-1:0]     scr_addr,
    output pixel_t            scr_data,
    output logic              line,
    output logic              fb_done,
    // DDR port
    input  logic              ddram_busy,
    input  logic              ddram_dout_ready,
    input  logic [DDR_DW-1:0] ddram_dout,
    output logic              ddram_rd,
    output logic              ddram_we,
    output logic [DDR_AW-1:0] ddram_addr,
    output logic [DDR_DW-1:0] ddram_din,
    output logic [7:0]        ddram_be,
    output logic [HW:0]       ddram_burstcnt
);

    logic [HW:0]   fb_addr;
    logic          fb_clr;
    pixel_t        fb_data;
    logic          scr_we;
    logic [HW-1:0] rd_addr;
    pixel_t        scr_wdata;
    logic          wr_grant;
    logic          rd_grant;
    ddr_req_t      wr_req;
    ddr_req_t      rd_req;
    ddr_rsp_t      rsp;

    // render memory holds two halves, line selects the one being drawn
    lfbuf_line_ram #(.HW(HW + 1)) render_ram_i (
        .clk(clk), .we(pxl_we), .waddr({line, pxl_addr}), .wdata(pxl_data),
        .raddr(fb_addr), .rdata(fb_data), .clr(fb_clr)
    );

    // screen memory is never cleared, each blank overwrites it
    lfbuf_line_ram #(.HW(HW)) screen_ram_i (
        .clk(clk), .we(scr_we), .waddr(rd_addr), .wdata(scr_wdata),
        .raddr(scr_addr), .rdata(scr_data), .clr(1'b0)
    );

    lfbuf_line_writer #(.HW(HW), .VW(VW)) writer_i (
        .clk(clk), .rst(rst), .ln_done(ln_done), .ln_v(ln_v), .frame(frame),
        .line(line), .fb_done(fb_done), .ram_addr(fb_addr), .ram_clr(fb_clr),
        .ram_data(fb_data), .grant(wr_grant), .req(wr_req), .rsp(rsp)
    );

    lfbuf_scan_reader #(.HW(HW), .VW(VW)) reader_i (
        .clk(clk), .rst(rst), .lhbl(lhbl), .vrender(vrender), .frame(frame),
        .scr_we(scr_we), .rd_addr(rd_addr), .scr_wdata(scr_wdata),
        .grant(rd_grant), .req(rd_req), .rsp(rsp)
    );

    lfbuf_ddr_arbiter #(.HW(HW)) arbiter_i (
        .clk(clk), .rst(rst), .wr_req(wr_req), .rd_req(rd_req),
        .wr_grant(wr_grant), .rd_grant(rd_grant), .rsp(rsp),
        .ddram_busy(ddram_busy), .ddram_dout_ready(ddram_dout_ready),
        .ddram_dout(ddram_dout), .ddram_rd(ddram_rd), .ddram_we(ddram_we),
        .ddram_addr(ddram_addr), .ddram_din(ddram_din), .ddram_be(ddram_be),
        .ddram_burstcnt(ddram_burstcnt)
    );

endmodule

`default_nettype wire

/* source/lfbuf_ddr_arbiter.sv */
// **************************************************
// one DDR port shared by line writer and scan reader
// a read burst ends after 2^HW dout_ready beats
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module lfbuf_ddr_arbiter import lfbuf_pkg::*; #(
    parameter int HW = 9
) (
    input  logic              clk,
    input  logic              rst,
    input  ddr_req_t          wr_req,
    input  ddr_req_t          rd_req,
    output logic              wr_grant,
    output logic              rd_grant,
    output ddr_rsp_t          rsp,
    input  logic              ddram_busy,
    input  logic              ddram_dout_ready,
    input  logic [DDR_DW-1:0] ddram_dout,
    output logic              ddram_rd,
    output logic              ddram_we,
    output logic [DDR_AW-1:0] ddram_addr,
    output logic [DDR_DW-1:0] ddram_din,
    output logic [7:0]        ddram_be,
    output logic [HW:0]       ddram_burstcnt
);

    typedef enum logic {
        OWN_RD,
        OWN_WR
    } owner_t;

    owner_t        owner;
    logic          in_burst;
    logic [HW-1:0] beat_cnt;

    // grants are exclusive, so rd and we can never meet on the pins
    assign rd_grant = in_burst && (owner == OWN_RD);
    assign wr_grant = in_burst && (owner == OWN_WR);

    assign ddram_rd   = rd_grant && rd_req.rd;
    assign ddram_we   = wr_grant && wr_req.we;
    assign ddram_addr = (owner == OWN_RD) ? rd_req.addr : wr_req.addr;
    // pixel in the low half word, upper bytes masked by be
    assign ddram_din      = {{(DDR_DW-16){1'b0}}, wr_req.data};
    assign ddram_be       = DDR_BE;
    assign ddram_burstcnt = {1'b1, {HW{1'b0}}};

    assign rsp.busy       = ddram_busy;
    assign rsp.dout_ready = ddram_dout_ready;
    assign rsp.dout       = ddram_dout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner    <= OWN_RD;
            in_burst <= 1'b0;
            beat_cnt <= '0;
        end else if (!in_burst) begin
            beat_cnt <= '0;
            // reads first, the screen cannot wait past the blank
            if (rd_req.rd) begin
                owner    <= OWN_RD;
                in_burst <= 1'b1;
            end else if (wr_req.we) begin
                owner    <= OWN_WR;
                in_burst <= 1'b1;
            end
        end else if (owner == OWN_WR) begin
            // writer drops we after its last pixel
            if (!wr_req.we) begin
                in_burst <= 1'b0;
            end
        end else if (ddram_dout_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (&beat_cnt) begin
                in_burst <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/lfbuf_scan_reader.sv */
// **************************************************
// fetches one DDR line per horizontal blank
// a new blank before the burst ends is ignored
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module lfbuf_scan_reader import lfbuf_pkg::*; #(
    parameter int HW = 9,
    parameter int VW = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          lhbl,
    input  logic [VW-1:0] vrender,
    input  logic          frame,
    output logic          scr_we,
    output logic [HW-1:0] rd_addr,
    output pixel_t        scr_wdata,
    input  logic          grant,
    output ddr_req_t      req,
    input  ddr_rsp_t      rsp
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_DATA
    } rd_state_t;

    rd_state_t     state;
    logic          lhbl_l;
    logic [HW-1:0] beats;
    logic [VW-1:0] row;
    logic          bank;

    // rd stays up until the arbiter accepts it, one cycle when not stalled
    assign req.rd   = (state == RD_REQ);
    assign req.we   = 1'b0;
    assign req.data = '0;
    assign req.addr = {DDR_BASE, {(DDR_AW-5-VW-HW){1'b0}}, bank, row, {HW{1'b0}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= RD_IDLE;
            lhbl_l  <= 1'b0;
            beats   <= '0;
            rd_addr <= '0;
            scr_we  <= 1'b0;
        end else begin
            lhbl_l <= lhbl;
            scr_we <= 1'b0;
            // write address moves on after each stored beat
            if (scr_we) begin
                rd_addr <= rd_addr + 1'b1;
            end
            case (state)
                RD_IDLE: begin
                    if (lhbl && !lhbl_l) begin
                        state <= RD_REQ;
                    end
                end
                RD_REQ: begin
                    if (grant && !rsp.busy) begin
                        state   <= RD_DATA;
                        beats   <= '0;
                        rd_addr <= '0;
                    end
                end
                RD_DATA: begin
                    if (rsp.dout_ready) begin
                        scr_we <= 1'b1;
                        beats  <= beats + 1'b1;
                        if (&beats) begin
                            state <= RD_IDLE;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_IDLE && lhbl && !lhbl_l) begin
            row  <= vrender;
            // screen shows the bank not being written
            bank <= ~frame;
        end
        if (rsp.dout_ready) begin
            scr_wdata <= rsp.dout[15:0];
        end
    end

endmodule

`default_nettype wire

/* source/lfbuf_line_writer.sv */
// **************************************************
// copies a finished render line to DDR and clears it
// one pending line is kept, a third ln_done during a copy is lost
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module lfbuf_line_writer import lfbuf_pkg::*; #(
    parameter int HW = 9,
    parameter int VW = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          ln_done,
    input  logic [VW-1:0] ln_v,
    input  logic          frame,
    output logic          line,
    output logic          fb_done,
    output logic [HW:0]   ram_addr,
    output logic          ram_clr,
    input  pixel_t        ram_data,
    input  logic          grant,
    output ddr_req_t      req,
    input  ddr_rsp_t      rsp
);

    logic          ln_done_l;
    logic          ln_rise;
    logic          pend;
    logic          active;
    logic          step;
    logic [HW-1:0] idx;
    // line captured at ln_done, then moved to cur_* when the copy starts
    logic [VW-1:0] pend_v;
    logic          pend_half;
    logic          pend_frame;
    logic [VW-1:0] cur_v;
    logic          cur_half;
    logic          cur_frame;

    assign ln_rise = ln_done && !ln_done_l;
    // one pixel leaves per granted non-busy cycle
    assign step    = active && grant && !rsp.busy;

    assign ram_addr = {cur_half, idx};
    assign ram_clr  = step;

    assign req.rd   = 1'b0;
    assign req.we   = active;
    assign req.data = ram_data;
    // zero padding sits between the base nibble and the bank bit
    assign req.addr = {DDR_BASE, {(DDR_AW-5-VW-HW){1'b0}}, cur_frame, cur_v, idx};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ln_done_l <= 1'b0;
            pend      <= 1'b0;
            active    <= 1'b0;
            idx       <= '0;
            line      <= 1'b0;
            fb_done   <= 1'b0;
        end else begin
            ln_done_l <= ln_done;
            fb_done   <= 1'b0;
            if (active) begin
                if (step) begin
                    idx <= idx + 1'b1;
                    // idx wraps to zero for the next line
                    if (&idx) begin
                        active  <= 1'b0;
                        fb_done <= 1'b1;
                    end
                end
            end else if (pend) begin
                active <= 1'b1;
                pend   <= 1'b0;
            end
            // set after the start above so a rise on the start cycle is kept
            if (ln_rise) begin
                pend <= 1'b1;
                line <= ~line;
            end
        end
    end

    always_ff @(posedge clk) begin
        // renderer moves to the other half, copy the one it just left
        if (ln_rise) begin
            pend_v     <= ln_v;
            pend_half  <= line;
            pend_frame <= frame;
        end
        if (!active && pend) begin
            cur_v     <= pend_v;
            cur_half  <= pend_half;
            cur_frame <= pend_frame;
        end
    end

endmodule

`default_nettype wire

/* source/lfbuf_line_ram.sv */
// **************************************************
// line memory with asynchronous read
// clr zeroes the word at raddr, a write at the same address wins
// **************************************************
`timescale 1ns/1ns
`default_nettype none

module lfbuf_line_ram import lfbuf_pkg::*; #(
    parameter int HW = 9
) (
    input  logic          clk,
    input  logic          we,
    input  logic [HW-1:0] waddr,
    input  pixel_t        wdata,
    input  logic [HW-1:0] raddr,
    output pixel_t        rdata,
    input  logic          clr
);

    pixel_t mem [0:(2**HW)-1];

    // read side is combinational so the reader sees the word in the same cycle
    assign rdata = mem[raddr];

    always_ff @(posedge clk) begin
        // clear what was just read
        if (clr) begin
            mem[raddr] <= '0;
        end
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* source/lfbuf_pkg.sv */
// **************************************************
// shared types of the line-to-frame buffer
// only the low 16 bits of each 64-bit DDR word are used
// **************************************************
`default_nettype none

package lfbuf_pkg;

    // one rendered pixel
    typedef logic [15:0] pixel_t;

    // word address width of the DDR port, bits 31:3 of a byte address
    localparam int DDR_AW = 29;

    // data width of the DDR port
    localparam int DDR_DW = 64;

    // upper address nibble that places the frame area in DDR
    localparam logic [3:0] DDR_BASE = 4'd3;

    // only the two low bytes carry a pixel
    localparam logic [7:0] DDR_BE = 8'h03;

    // request from one client toward the arbiter
    // rd is held until accepted, we is a level for the whole burst
    typedef struct packed {
        logic              rd;
        logic              we;
        logic [DDR_AW-1:0] addr;
        pixel_t            data;
    } ddr_req_t;

    // what the arbiter hands back to both clients
    typedef struct packed {
        logic              busy;
        logic              dout_ready;
        logic [DDR_DW-1:0] dout;
    } ddr_rsp_t;

endpackage

`default_nettype wire
